/* Makefile */
TOP = tb_cpu_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f cpu6502_lite.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* cpu6502_lite.f */
+incdir+include
hw/cpu_pkg.sv
hw/alu.sv
hw/instruction_decode.sv
hw/datapath.sv
hw/cpu_core.sv
tests/tb_memory.sv
tests/tb_cpu_core.sv

/* hw/alu.sv */
module alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    input  logic             carry_in,
    output logic [7:0]       result,
    output cpu_pkg::status_t flags
);
    import cpu_pkg::*;

    logic [8:0] sum;

    assign sum = {1'b0, a} + {1'b0, b} + {8'h00, carry_in};

    always_comb begin
        result  = b;
        flags.c = carry_in; // C holds unless the op produces one
        flags.v = 1'b0;
        case (op)
            ALU_ADC: begin
                result  = sum[7:0];
                flags.c = sum[8];
                flags.v = (a[7] == b[7]) && (sum[7] != a[7]); // Signed overflow
            end
            ALU_AND: result = a & b;
            ALU_ORA: result = a | b;
            ALU_EOR: result = a ^ b;
            ALU_ASL: begin
                result  = {b[6:0], 1'b0};
                flags.c = b[7];
            end
            ALU_LSR: begin
                result  = {1'b0, b[7:1]};
                flags.c = b[0];
            end
            ALU_ROL: begin
                result  = {b[6:0], carry_in};
                flags.c = b[7];
            end
            ALU_ROR: begin
                result  = {carry_in, b[7:1]};
                flags.c = b[0];
            end
            ALU_INC: result = b + 8'd1;
            ALU_DEC: result = b - 8'd1;
            default: result = b; // Pass
        endcase
        flags.n = result[7];
        flags.z = (result == 8'h00);
    end

endmodule

/* hw/cpu_core.sv */
module cpu_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic [7:0]        rdata,
    output cpu_pkg::mem_req_t mem_req
);
    import cpu_pkg::*;

    ctrl_t   ctrl;
    status_t status;

    // Control FSM, sees the opcode on the shared read bus
    instruction_decode u_instruction_decode (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .rdata  (rdata),
        .status (status),
        .ctrl   (ctrl)
    );

    datapath u_datapath (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .ctrl    (ctrl),
        .rdata   (rdata),
        .status  (status),
        .mem_req (mem_req)
    );

endmodule

/* hw/cpu_pkg.sv */
`include "opcodes.svh"

package cpu_pkg;

    localparam logic [15:0] RESET_PC = 16'h0200; // First opcode fetch after reset

    typedef enum logic [2:0] {
        S_FETCH    = 3'd0, // Opcode read at PC
        S_ZPG_ADDR = 3'd1, // Operand byte at PC (zpg address or branch offset)
        S_READ     = 3'd2, // Zero-page read
        S_MODIFY   = 3'd3, // RMW operation on the data latch
        S_WRITE    = 3'd4, // Zero-page write
        S_BRANCH   = 3'd5  // Extra cycle of a taken branch
    } cpu_state_e;

    // Read-modify-write operations sit at the top of the encoding
    typedef enum logic [3:0] {
        ALU_PASS = 4'd0,
        ALU_ADC  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_ORA  = 4'd3,
        ALU_EOR  = 4'd4,
        ALU_ASL  = 4'd5,
        ALU_LSR  = 4'd6,
        ALU_ROL  = 4'd7,
        ALU_ROR  = 4'd8,
        ALU_INC  = 4'd9,
        ALU_DEC  = 4'd10
    } alu_op_e;

    typedef enum logic {
        ADDR_PC  = 1'b0,
        ADDR_ZPG = 1'b1
    } addr_src_e;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } status_t;

    typedef struct packed {
        logic      pc_inc;      // PC + 1
        logic      branch_take; // PC + 1 + offset, with pc_inc
        addr_src_e addr_src;
        logic      zpg_load;    // Latch zero-page address from rdata
        logic      data_load;   // Latch ALU result into the data latch
        alu_op_e   alu_op;
        logic      acc_load;
        logic      flags_load;
        logic      wr_en;
    } ctrl_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mem_req_t;

endpackage

/* hw/datapath.sv */
module datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  cpu_pkg::ctrl_t    ctrl,
    input  logic [7:0]        rdata,
    output cpu_pkg::status_t  status,
    output cpu_pkg::mem_req_t mem_req
);
    import cpu_pkg::*;

    logic [7:0]  acc_q;
    logic [15:0] pc_q;
    logic [7:0]  zpg_q;
    logic [7:0]  data_q;
    status_t     status_q;

    logic        rmw_op;
    logic [7:0]  alu_b;
    logic [7:0]  alu_result;
    status_t     alu_flags;
    logic [15:0] pc_next;
    logic [15:0] branch_offset;

    assign rmw_op        = (ctrl.alu_op >= ALU_ASL); // Shift, rotate, inc, dec
    assign alu_b         = rmw_op ? data_q : rdata;
    assign pc_next       = pc_q + 16'd1;
    assign branch_offset = {{8{rdata[7]}}, rdata}; // Sign-extended relative offset

    alu u_alu (
        .op       (ctrl.alu_op),
        .a        (acc_q),
        .b        (alu_b),
        .carry_in (status_q.c),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q    <= 8'h00;
            pc_q     <= RESET_PC;
            status_q <= '0;
        end else if (rdy) begin
            if (ctrl.acc_load) begin
                acc_q <= alu_result;
            end
            if (ctrl.flags_load) begin
                status_q.n <= alu_flags.n;
                status_q.z <= alu_flags.z;
                status_q.c <= alu_flags.c;
                if (ctrl.alu_op == ALU_ADC) begin
                    status_q.v <= alu_flags.v; // Only ADC touches V
                end
            end
            if (ctrl.branch_take) begin
                pc_q <= pc_next + branch_offset;
            end else if (ctrl.pc_inc) begin
                pc_q <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (ctrl.zpg_load) begin
                zpg_q <= rdata;
            end
            if (ctrl.data_load) begin
                data_q <= alu_result; // Operand, then the modified byte
            end
        end
    end

    assign status        = status_q;
    assign mem_req.addr  = (ctrl.addr_src == ADDR_ZPG) ? {8'h00, zpg_q} : pc_q;
    assign mem_req.wdata = rmw_op ? data_q : acc_q; // RMW result or STA
    assign mem_req.we    = ctrl.wr_en;

endmodule

/* hw/instruction_decode.sv */
module instruction_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic [7:0]       rdata,
    input  cpu_pkg::status_t status,
    output cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_d;
    logic [7:0] opcode_q;

    function automatic alu_op_e op_to_alu(input logic [7:0] op);
        case (op)
            `OP_ADC_ZPG: return ALU_ADC;
            `OP_AND_ZPG: return ALU_AND;
            `OP_ORA_ZPG: return ALU_ORA;
            `OP_EOR_ZPG: return ALU_EOR;
            `OP_ASL_ZPG: return ALU_ASL;
            `OP_LSR_ZPG: return ALU_LSR;
            `OP_ROL_ZPG: return ALU_ROL;
            `OP_ROR_ZPG: return ALU_ROR;
            `OP_INC_ZPG: return ALU_INC;
            `OP_DEC_ZPG: return ALU_DEC;
            default:     return ALU_PASS; // LDA, STA
        endcase
    endfunction

    function automatic logic is_read_op(input logic [7:0] op);
        return op inside {`OP_LDA_ZPG, `OP_ADC_ZPG, `OP_AND_ZPG, `OP_ORA_ZPG, `OP_EOR_ZPG};
    endfunction

    function automatic logic is_rmw_op(input logic [7:0] op);
        return op inside {`OP_ASL_ZPG, `OP_LSR_ZPG, `OP_ROL_ZPG,
                          `OP_ROR_ZPG, `OP_INC_ZPG, `OP_DEC_ZPG};
    endfunction

    function automatic logic is_branch_op(input logic [7:0] op);
        return op inside {`OP_BEQ_REL, `OP_BNE_REL, `OP_BCC_REL, `OP_BCS_REL};
    endfunction

    function automatic logic branch_cond(input logic [7:0] op, input status_t st);
        case (op)
            `OP_BEQ_REL: return st.z;
            `OP_BNE_REL: return !st.z;
            `OP_BCC_REL: return !st.c;
            default:     return st.c; // BCS
        endcase
    endfunction

    always_comb begin
        state_d       = state_q;
        ctrl          = '0;
        ctrl.alu_op   = ALU_PASS;
        ctrl.addr_src = ADDR_PC;
        case (state_q)
            S_FETCH: begin
                ctrl.pc_inc = 1'b1; // Opcode on rdata, latched below
                state_d     = S_ZPG_ADDR;
            end
            S_ZPG_ADDR: begin
                if (is_branch_op(opcode_q)) begin
                    ctrl.pc_inc = 1'b1;
                    if (branch_cond(opcode_q, status)) begin
                        ctrl.branch_take = 1'b1; // Offset is on rdata now
                        state_d          = S_BRANCH;
                    end else begin
                        state_d = S_FETCH;
                    end
                end else if (is_read_op(opcode_q) || is_rmw_op(opcode_q) ||
                             opcode_q == `OP_STA_ZPG) begin
                    ctrl.pc_inc   = 1'b1;
                    ctrl.zpg_load = 1'b1;
                    state_d       = (opcode_q == `OP_STA_ZPG) ? S_WRITE : S_READ;
                end else begin
                    state_d = S_FETCH; // Unknown opcode, two-cycle no-op
                end
            end
            S_READ: begin
                ctrl.addr_src = ADDR_ZPG;
                if (is_rmw_op(opcode_q)) begin
                    ctrl.data_load = 1'b1; // Pass operand into the data latch
                    state_d        = S_MODIFY;
                end else begin
                    ctrl.alu_op     = op_to_alu(opcode_q);
                    ctrl.acc_load   = 1'b1;
                    ctrl.flags_load = 1'b1;
                    state_d         = S_FETCH;
                end
            end
            S_MODIFY: begin
                ctrl.addr_src   = ADDR_ZPG;
                ctrl.alu_op     = op_to_alu(opcode_q);
                ctrl.data_load  = 1'b1;
                ctrl.flags_load = 1'b1;
                state_d         = S_WRITE;
            end
            S_WRITE: begin
                ctrl.addr_src = ADDR_ZPG;
                ctrl.alu_op   = op_to_alu(opcode_q); // Selects the write source
                ctrl.wr_en    = 1'b1;
                state_d       = S_FETCH;
            end
            S_BRANCH: begin
                state_d = S_FETCH; // PC already holds the target
            end
            default: begin
                state_d = S_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_FETCH;
        end else if (rdy) begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state_q == S_FETCH) begin
            opcode_q <= rdata;
        end
    end

endmodule

/* include/opcodes.svh */
`ifndef OPCODES_SVH
`define OPCODES_SVH

// Zero-page loads and ALU reads
`define OP_LDA_ZPG 8'hA5
`define OP_ADC_ZPG 8'h65
`define OP_AND_ZPG 8'h25
`define OP_ORA_ZPG 8'h05
`define OP_EOR_ZPG 8'h45

// Zero-page store
`define OP_STA_ZPG 8'h85

// Zero-page read-modify-write
`define OP_ASL_ZPG 8'h06
`define OP_LSR_ZPG 8'h46
`define OP_ROL_ZPG 8'h26
`define OP_ROR_ZPG 8'h66
`define OP_INC_ZPG 8'hE6
`define OP_DEC_ZPG 8'hC6

// Relative branches, offset byte follows the opcode
`define OP_BEQ_REL 8'hF0
`define OP_BNE_REL 8'hD0
`define OP_BCC_REL 8'h90
`define OP_BCS_REL 8'hB0

`endif

/* tests/tb_cpu_core.sv */
`include "opcodes.svh"

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int CYCLE    = 20;
    localparam int N_WRITES = 18;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } write_t;

    logic       clk;
    logic       rst;
    logic       rdy;
    logic [7:0] rdata;
    mem_req_t   mem_req;
    mem_req_t   wr_log;

    // Program at RESET_PC that ends in a branch to itself
    logic [7:0] prog_image [76] = '{
        `OP_LDA_ZPG, 8'h10, `OP_STA_ZPG, 8'h20, `OP_ADC_ZPG, 8'h11, `OP_STA_ZPG, 8'h21,
        `OP_ADC_ZPG, 8'h13, `OP_STA_ZPG, 8'h22, `OP_AND_ZPG, 8'h12, `OP_STA_ZPG, 8'h23,
        `OP_ORA_ZPG, 8'h13, `OP_STA_ZPG, 8'h24, `OP_EOR_ZPG, 8'h10, `OP_STA_ZPG, 8'h25,
        `OP_ASL_ZPG, 8'h13, `OP_ROR_ZPG, 8'h11, `OP_ROL_ZPG, 8'h12, `OP_LSR_ZPG, 8'h10,
        `OP_ROL_ZPG, 8'h10, `OP_INC_ZPG, 8'h14, `OP_DEC_ZPG, 8'h15, `OP_BEQ_REL, 8'h02,
        `OP_STA_ZPG, 8'h26, `OP_BNE_REL, 8'h02, `OP_STA_ZPG, 8'h27, `OP_BCC_REL, 8'h02,
        `OP_STA_ZPG, 8'h28, `OP_BCS_REL, 8'h02, `OP_STA_ZPG, 8'h29, `OP_LDA_ZPG, 8'h14,
        `OP_BEQ_REL, 8'h02, `OP_STA_ZPG, 8'h2A, `OP_BNE_REL, 8'h02, `OP_STA_ZPG, 8'h2B,
        `OP_ASL_ZPG, 8'h15, `OP_BCS_REL, 8'h02, `OP_STA_ZPG, 8'h2C, `OP_BCC_REL, 8'h02,
        `OP_STA_ZPG, 8'h2D, `OP_BCS_REL, 8'hFE
    };

    logic [7:0] zpg_data [6] = '{8'h5A, 8'hC3, 8'h0F, 8'h81, 8'hFF, 8'h00}; // At 0010..0015

    // Skipped stores (27, 28, 2A, 2C) must never show up
    write_t exp_writes [N_WRITES] = '{
        24'h00205A, 24'h00211D, 24'h00229F, 24'h00230F, 24'h00248F, 24'h0025D5,
        24'h001302, 24'h0011E1, 24'h00121F, 24'h00102D, 24'h00105A, 24'h001400,
        24'h0015FF, 24'h0026D5, 24'h0029D5, 24'h002B00, 24'h0015FE, 24'h002D00
    };
    string write_names [N_WRITES] = '{
        "lda_sta", "adc", "adc_carry_chain", "and", "ora", "eor",
        "asl", "ror_carry_in", "rol_carry_in", "lsr", "rol", "inc_wrap",
        "dec_wrap", "beq_not_taken", "bne_bcc_taken", "beq_taken", "asl_carry", "bcs_taken"
    };

    cpu_core u_cpu_core (.*);

    tb_memory u_tb_memory (.*);

    always #(CYCLE / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < 76; i++) begin
            u_tb_memory.mem[RESET_PC + 16'(i)] = prog_image[i];
        end
        for (int i = 0; i < 6; i++) begin
            u_tb_memory.mem[16'h0010 + 16'(i)] = zpg_data[i];
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        @(negedge clk);
        load_image(); // Memory background is in place by now
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_WRITES; i++) begin
            do @(negedge clk); while (!wr_log.we);
            check_value(write_names[i], exp_writes[i], {wr_log.addr, wr_log.wdata});
        end
        $display("Test OK");
        $finish;
    end

    // About 20 cycles per write and twice that for stalls
    initial begin
        #(N_WRITES * 20 * 2 * CYCLE);
        $display("Timeout, the core did not produce the expected writes in time");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

/* tests/tb_memory.sv */
module tb_memory (
    input  logic              clk,
    input  cpu_pkg::mem_req_t mem_req,
    output logic [7:0]        rdata,
    output logic              rdy,
    output cpu_pkg::mem_req_t wr_log // Write taken at the last rising edge when we is set
);
    import cpu_pkg::*;

    logic [7:0] mem [65536];

    initial begin
        void'($urandom(60026));
        rdy = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h3C; // Background pattern
        end
        forever begin
            @(negedge clk);
            rdy = ($urandom % 4) != 0; // Stall about one cycle in four
        end
    end

    assign rdata = mem[mem_req.addr]; // Combinational read

    always @(posedge clk) begin
        wr_log <= '0;
        if (mem_req.we && rdy) begin
            mem[mem_req.addr] = mem_req.wdata;
            wr_log <= mem_req;
        end
    end

endmodule
